/* tb.f */
+incdir+.
bldc_pkg.sv
bldc_regs.sv
hall_decoder.sv
pwm_gen.sv
dead_time.sv
motor_ctrl.sv
bldc_top.sv
tb_bldc.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the BLDC gate driver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_bldc \
  -f tb.f \
  -o sim_bldc

# A $fatal in the testbench gives a failing exit status
./obj_dir/sim_bldc

/* tb_bldc_model.svh */
/*
 Reference model of the BLDC gate driver for the testbench.
 Commutation tables per phase, steady gate levels and high-side width.
 Included inside tb_bldc after the bldc_pkg import.
*/
`ifndef TB_BLDC_MODEL_SVH
`define TB_BLDC_MODEL_SVH

  // Leg letter for one phase, H high, L low, F float
  function automatic byte leg_char(bit star, bit cw, int step, int phase);
    string row;
    byte   c;
    if (star)
    begin
      case (step)
        0:       row = "HLF";
        1:       row = "FHL";
        2:       row = "HFL";
        3:       row = "LHF";
        4:       row = "FLH";
        default: row = "LFH";
      endcase
    end
    else
    begin
      case (step)
        0:       row = "HLL";
        1:       row = "LHL";
        2:       row = "HHL";
        3:       row = "LLH";
        4:       row = "HLH";
        default: row = "LHH";
      endcase
    end
    c = row[phase];
    // Counter-clockwise swaps the two driven sides
    if (!cw)
    begin
      if (c == "H")
        c = "L";
      else if (c == "L")
        c = "H";
    end
    return c;
  endfunction

  // Steady {hi, lo} at duty 0 or full duty
  function automatic logic [1:0] leg_level(byte c, bit full);
    case (c)
      "H":     return full ? 2'b10 : 2'b01;
      "L":     return 2'b01;
      default: return 2'b00;
    endcase
  endfunction

  // High-side on cycles in one PWM period
  function automatic int hi_width(int d);
    return (d > DEAD_CYCLES) ? d - DEAD_CYCLES : 0;
  endfunction

`endif

/* tb_bldc.sv */
/*
 Testbench for the BLDC gate driver, one clock of 100 ns.
 Random settings from a fixed seed, checked against the included model.
 Gates and bus responses are sampled on the falling edge.
*/
`timescale 1ns/100ps

module tb_bldc
  import bldc_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int PERIOD       = 2 ** PWM_BITS;
  localparam int WB_CYCLES    = 8;
  localparam int ACK_LIMIT    = 16;
  localparam int SETTLE       = 24;
  localparam int ALIGN_MARGIN = 16;
  localparam int N_REG        = 8;
  localparam int N_POS        = 6;
  localparam int N_PWM        = 6;

  // ------------------------------------------------
  // Cycle budget of each test
  // ------------------------------------------------
  localparam int START_LEN = ALIGN_CYCLES + ALIGN_MARGIN + 3 * WB_CYCLES;
  localparam int REG_LEN   = SETTLE + (N_REG * 4 + 1) * WB_CYCLES;
  localparam int ALIGN_LEN = START_LEN + 2 * WB_CYCLES + SETTLE;
  localparam int COMM_LEN  = START_LEN + 4 * (WB_CYCLES + N_POS * (SETTLE + 3 * WB_CYCLES));
  localparam int PWM_LEN   = N_PWM * (3 * PERIOD + 3 * WB_CYCLES);
  localparam int FAULT_LEN = 2 * SETTLE + 4 * WB_CYCLES;
  localparam int TIMEOUT_CYCLES =
    REG_LEN + ALIGN_LEN + COMM_LEN + PWM_LEN + FAULT_LEN + 1000;

  logic                 clk;
  logic                 rst_n;
  wb_req_t              wb_req;
  wb_rsp_t              wb_rsp;
  logic [2:0]           hall;
  gate_pair_t [2:0]     gates;
  int                   seed;

  bldc_top bldc_top_i (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_i     (wb_req),
    .wb_o     (wb_rsp),
    .hall_i   (hall),
    .gate_a_o (gates[0]),
    .gate_b_o (gates[1]),
    .gate_c_o (gates[2])
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "tb_bldc_model.svh"

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic int pick(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [15:0] ctrl_word(bit run, bit star, bit cw, bit clr);
    return {12'd0, clr, cw, star, run};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic set_hall(input logic [2:0] code);
    @(posedge clk);
    hall <= code;
  endtask

  // One Wishbone classic cycle, held until ack
  task automatic bus_access(input bit we, input logic [1:0] adr,
                            input logic [15:0] wdat, output logic [15:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= we;
    wb_req.adr <= adr;
    wb_req.dat <= wdat;
    @(negedge clk);
    while (!wb_rsp.ack)
    begin
      waited++;
      if (waited > ACK_LIMIT)
        abort_run($sformatf("No Wishbone ack within %0d cycles", ACK_LIMIT));
      @(negedge clk);
    end
    rdat = wb_rsp.dat;
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic write_reg(input logic [1:0] adr, input logic [15:0] dat);
    logic [15:0] discard;
    bus_access(1'b1, adr, dat, discard);
  endtask

  task automatic read_reg(input logic [1:0] adr, output logic [15:0] dat);
    bus_access(1'b0, adr, 16'd0, dat);
  endtask

  // Compare all three legs with the model
  task automatic check_legs(input bit star, input bit cw, input int step, input bit full);
    for (int p = 0; p < 3; p++)
      check_value($sformatf("gate_%c_o", 8'(97 + p)), 32'(gates[p]),
                  32'(leg_level(leg_char(star, cw, step, p), full)));
  endtask

  // Motor stopped, all six gates low
  task automatic check_gates_low();
    for (int p = 0; p < 3; p++)
      check_value($sformatf("gate_%c_o", 8'(97 + p)), 32'(gates[p]), 32'd0);
  endtask

  // Set run, see ALIGN, then RUN once the align time is over
  task automatic start_motor(input bit star, input bit cw);
    logic [15:0] st;
    write_reg(ADDR_CTRL, ctrl_word(1'b1, star, cw, 1'b0));
    read_reg(ADDR_STATUS, st);
    check_value("status.state", 32'(st[1:0]), 32'(ALIGN));
    wait_cycles(ALIGN_CYCLES + ALIGN_MARGIN);
    read_reg(ADDR_STATUS, st);
    check_value("status.state", 32'(st[1:0]), 32'(RUN));
  endtask

  // ------------------------------------------------
  // Watchdog
  // ------------------------------------------------
  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Watchdog expired after %0d cycles, the run did not finish",
                        TIMEOUT_CYCLES));
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial
  begin
    logic [15:0] rd;
    logic [15:0] ctrl;
    logic [15:0] duty;
    bit          star;
    bit          cw;
    bit          full;
    int          pos;
    int          cnt;
    int          ph;
    int          d;

    clk    = 1'b0;
    rst_n  = 1'b0;
    wb_req = '0;
    hall   = 3'd1;
    seed   = 20748;
    wait_cycles(3);
    rst_n <= 1'b1;

    // Register access and reset state, gates given time past the dead time
    wait_cycles(SETTLE);
    @(negedge clk);
    check_gates_low();
    read_reg(ADDR_STATUS, rd);
    check_value("status.state", 32'(rd[1:0]), 32'(OFF));
    check_value("status.hall_fault", 32'(rd[2]), 32'd0);
    for (int i = 0; i < N_REG; i++)
    begin
      // run stays clear here
      ctrl = 16'(pick(16)) & 16'h000e;
      duty = 16'(pick(2 ** DUTY_W));
      write_reg(ADDR_CTRL, ctrl);
      write_reg(ADDR_DUTY, duty);
      read_reg(ADDR_CTRL, rd);
      check_value("ctrl", 32'(rd), 32'(ctrl & 16'h0006));
      read_reg(ADDR_DUTY, rd);
      check_value("duty", 32'(rd), 32'(duty));
    end

    // Align sequence, then back to OFF
    start_motor(1'b1, 1'b1);
    write_reg(ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b1, 1'b0));
    read_reg(ADDR_STATUS, rd);
    check_value("status.state", 32'(rd[1:0]), 32'(OFF));
    wait_cycles(DEAD_CYCLES + 6);
    @(negedge clk);
    check_gates_low();

    // Commutation for all four tables
    start_motor(1'b1, 1'b1);
    for (int c = 0; c < 4; c++)
    begin
      star = c[1];
      cw   = c[0];
      write_reg(ADDR_CTRL, ctrl_word(1'b1, star, cw, 1'b0));
      for (int i = 0; i < N_POS; i++)
      begin
        pos  = pick(6) + 1;
        full = pick(2) != 0;
        set_hall(3'(pos));
        write_reg(ADDR_DUTY, full ? 16'(2 ** PWM_BITS) : 16'd0);
        wait_cycles(SETTLE);
        @(negedge clk);
        check_legs(star, cw, pos - 1, full);
        read_reg(ADDR_STATUS, rd);
        check_value("status.position", 32'(rd[5:3]), 32'(pos));
      end
    end

    // PWM width on the first high leg
    for (int i = 0; i < N_PWM; i++)
    begin
      star = pick(2) != 0;
      cw   = pick(2) != 0;
      pos  = pick(6) + 1;
      d    = pick(PERIOD);
      write_reg(ADDR_CTRL, ctrl_word(1'b1, star, cw, 1'b0));
      write_reg(ADDR_DUTY, 16'(d));
      set_hall(3'(pos));
      wait_cycles(2 * PERIOD);
      ph = 0;
      for (int p = 2; p >= 0; p--)
        if (leg_char(star, cw, pos - 1, p) == "H")
          ph = p;
      cnt = 0;
      repeat (PERIOD)
      begin
        @(negedge clk);
        for (int p = 0; p < 3; p++)
          check_value($sformatf("gate_%c_o overlap", 8'(97 + p)),
                      32'(gates[p].hi & gates[p].lo), 32'd0);
        if (gates[ph].hi)
          cnt++;
      end
      check_value($sformatf("gate_%c_o.hi on cycles", 8'(97 + ph)), 32'(cnt),
                  32'(hi_width(d)));
    end

    // Hall fault and recovery
    set_hall(pick(2) != 0 ? 3'd7 : 3'd0);
    wait_cycles(SETTLE);
    read_reg(ADDR_STATUS, rd);
    check_value("status.hall_fault", 32'(rd[2]), 32'd1);
    check_value("status.state", 32'(rd[1:0]), 32'(OFF));
    @(negedge clk);
    check_gates_low();
    set_hall(3'(pick(6) + 1));
    wait_cycles(SETTLE);
    write_reg(ADDR_CTRL, ctrl_word(1'b1, star, cw, 1'b1));
    read_reg(ADDR_STATUS, rd);
    check_value("status.hall_fault", 32'(rd[2]), 32'd0);
    check_value("status.state", 32'(rd[1:0]), 32'(ALIGN));

    $display("Testbench passed");
    $finish;
  end

endmodule

/* bldc_top.sv */
/*
 BLDC gate driver top level, single clock domain.
 Host access over Wishbone classic, Hall inputs are asynchronous.
 Gate outputs are active high, hi and lo per phase.
*/
`timescale 1ns/100ps

module bldc_top
  import bldc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  wb_req_t    wb_i,
  output wb_rsp_t    wb_o,
  input  logic [2:0] hall_i,
  output gate_pair_t gate_a_o,
  output gate_pair_t gate_b_o,
  output gate_pair_t gate_c_o
);

  motor_cfg_t        cfg;
  motor_state_e      state;
  logic [2:0]        position;
  logic              hall_fault;
  logic [DUTY_W-1:0] duty;
  logic              pwm_on;
  leg_set_t          legs;

  bldc_regs regs_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wb_i         (wb_i),
    .wb_o         (wb_o),
    .state_i      (state),
    .hall_fault_i (hall_fault),
    .position_i   (position),
    .cfg_o        (cfg)
  );

  hall_decoder hall_i0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .hall_i      (hall_i),
    .fault_clr_i (cfg.fault_clr),
    .position_o  (position),
    .fault_o     (hall_fault)
  );

  motor_ctrl ctrl_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_i      (cfg),
    .position_i (position),
    .fault_i    (hall_fault),
    .state_o    (state),
    .duty_o     (duty),
    .leg_o      (legs)
  );

  pwm_gen pwm_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .duty_i   (duty),
    .pwm_on_o (pwm_on)
  );

  // ------------------------------------------------
  // Phase legs
  // ------------------------------------------------
  dead_time leg_a (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cmd_i    (legs[0]),
    .pwm_on_i (pwm_on),
    .gate_o   (gate_a_o)
  );

  dead_time leg_b (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cmd_i    (legs[1]),
    .pwm_on_i (pwm_on),
    .gate_o   (gate_b_o)
  );

  dead_time leg_c (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cmd_i    (legs[2]),
    .pwm_on_i (pwm_on),
    .gate_o   (gate_c_o)
  );

endmodule

/* motor_ctrl.sv */
/*
 OFF, ALIGN, RUN state machine and six-step commutation lookup.
 ALIGN drives step 0 at ALIGN_DUTY for ALIGN_CYCLES cycles.
 RUN uses step = position - 1 from the star or delta table.
 OFF floats all three legs, so every gate is low.
 Clearing run or a Hall fault returns to OFF on the next cycle.
*/
`timescale 1ns/100ps

module motor_ctrl
  import bldc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  motor_cfg_t        cfg_i,
  input  logic [2:0]        position_i,
  input  logic              fault_i,
  output motor_state_e      state_o,
  output logic [DUTY_W-1:0] duty_o,
  output leg_set_t          leg_o
);

  motor_state_e       state_q;
  logic [ALIGN_W-1:0] align_cnt_q;
  logic [2:0]         step;
  leg_set_t           tbl;

  // Pack one table row, phase A first
  function automatic leg_set_t row(leg_cmd_e a, leg_cmd_e b, leg_cmd_e c);
    leg_set_t r;
    r[0] = a;
    r[1] = b;
    r[2] = c;
    return r;
  endfunction

  // Counter-clockwise swaps high and low
  function automatic leg_cmd_e flip(leg_cmd_e c);
    case (c)
      LEG_HIGH: return LEG_LOW;
      LEG_LOW:  return LEG_HIGH;
      default:  return LEG_FLOAT;
    endcase
  endfunction

  // ------------------------------------------------
  // State machine
  // ------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= OFF;
      align_cnt_q <= '0;
    end
    else
    begin
      align_cnt_q <= '0;
      if (!cfg_i.run || fault_i)
        state_q <= OFF;
      else
      begin
        case (state_q)
          OFF:   state_q <= ALIGN;
          ALIGN:
          begin
            align_cnt_q <= align_cnt_q + ALIGN_W'(1);
            if (align_cnt_q == ALIGN_W'(ALIGN_CYCLES - 1))
              state_q <= RUN;
          end
          RUN:     state_q <= RUN;
          default: state_q <= OFF;
        endcase
      end
    end
  end

  assign state_o = state_q;

  // Effective duty per state
  always_comb
  begin
    case (state_q)
      ALIGN:   duty_o = ALIGN_DUTY;
      RUN:     duty_o = cfg_i.duty;
      default: duty_o = '0;
    endcase
  end

  // ------------------------------------------------
  // Commutation lookup
  // ------------------------------------------------
  assign step = (state_q == RUN) ? position_i - 3'd1 : 3'd0;

  always_comb
  begin
    // Clockwise tables
    if (cfg_i.star)
    begin
      case (step)
        3'd0:    tbl = row(LEG_HIGH,  LEG_LOW,   LEG_FLOAT);
        3'd1:    tbl = row(LEG_FLOAT, LEG_HIGH,  LEG_LOW);
        3'd2:    tbl = row(LEG_HIGH,  LEG_FLOAT, LEG_LOW);
        3'd3:    tbl = row(LEG_LOW,   LEG_HIGH,  LEG_FLOAT);
        3'd4:    tbl = row(LEG_FLOAT, LEG_LOW,   LEG_HIGH);
        3'd5:    tbl = row(LEG_LOW,   LEG_FLOAT, LEG_HIGH);
        default: tbl = row(LEG_FLOAT, LEG_FLOAT, LEG_FLOAT);
      endcase
    end
    else
    begin
      case (step)
        3'd0:    tbl = row(LEG_HIGH, LEG_LOW,  LEG_LOW);
        3'd1:    tbl = row(LEG_LOW,  LEG_HIGH, LEG_LOW);
        3'd2:    tbl = row(LEG_HIGH, LEG_HIGH, LEG_LOW);
        3'd3:    tbl = row(LEG_LOW,  LEG_LOW,  LEG_HIGH);
        3'd4:    tbl = row(LEG_HIGH, LEG_LOW,  LEG_HIGH);
        3'd5:    tbl = row(LEG_LOW,  LEG_HIGH, LEG_HIGH);
        default: tbl = row(LEG_FLOAT, LEG_FLOAT, LEG_FLOAT);
      endcase
    end
  end

  // Motor stopped, all legs float
  assign leg_o = (state_q == OFF) ? row(LEG_FLOAT, LEG_FLOAT, LEG_FLOAT) :
                 cfg_i.dir_cw     ? tbl : row(flip(tbl[0]), flip(tbl[1]), flip(tbl[2]));

endmodule

/* dead_time.sv */
/*
 One phase leg: complementary gate pair with turn-on delay.
 Each gate turns on DEAD_CYCLES after its request is steadily high,
 and off with its request, so every on-pulse shortens by DEAD_CYCLES.
*/
`timescale 1ns/100ps

module dead_time
  import bldc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  leg_cmd_e   cmd_i,
  input  logic       pwm_on_i,
  output gate_pair_t gate_o
);

  // Index 1 is the high side, 0 the low side
  logic [1:0]        req;
  logic [1:0]        on_q;
  logic [DEAD_W-1:0] cnt_q [2];

  // Low side takes the PWM off-time of a high leg
  assign req[1] = (cmd_i == LEG_HIGH) && pwm_on_i;
  assign req[0] = (cmd_i == LEG_LOW) || ((cmd_i == LEG_HIGH) && !pwm_on_i);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      on_q     <= 2'b00;
      cnt_q[0] <= '0;
      cnt_q[1] <= '0;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        if (!req[i])
          cnt_q[i] <= '0;
        else if (cnt_q[i] != DEAD_W'(DEAD_CYCLES))
          cnt_q[i] <= cnt_q[i] + DEAD_W'(1);
        // Off in the same cycle the request drops
        on_q[i] <= req[i] && (cnt_q[i] == DEAD_W'(DEAD_CYCLES));
      end
    end
  end

  assign gate_o.hi = on_q[1];
  assign gate_o.lo = on_q[0];

  // Shoot-through guard
  a_no_overlap : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(gate_o.hi && gate_o.lo));

endmodule

/* pwm_gen.sv */
/*
 Free-running PWM counter, period 2**PWM_BITS cycles.
 pwm_on_o is registered; a duty of 2**PWM_BITS or more means always on.
*/
`timescale 1ns/100ps

module pwm_gen
  import bldc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [DUTY_W-1:0] duty_i,
  output logic              pwm_on_o
);

  logic [PWM_BITS-1:0] cnt_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q    <= '0;
      pwm_on_o <= 1'b0;
    end
    else
    begin
      // Wraps by overflow
      cnt_q <= cnt_q + PWM_BITS'(1);
      // High while the count is below the duty
      pwm_on_o <= ({1'b0, cnt_q} < duty_i);
    end
  end

endmodule

/* hall_decoder.sv */
/*
 Hall sensor front end: two-flop synchronizer and stability filter.
 A code is accepted after HALL_STABLE equal cycles.
 Codes 0 and 7 set a sticky fault; the last valid position is kept.
*/
`timescale 1ns/100ps

module hall_decoder
  import bldc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [2:0] hall_i,
  input  logic       fault_clr_i,
  output logic [2:0] position_o,
  output logic       fault_o
);

  logic [2:0]            sync1_q;
  logic [2:0]            sync2_q;
  logic [2:0]            cand_q;
  logic [HALL_CNT_W-1:0] cnt_q;
  logic                  accept;
  logic                  bad_code;

  // Candidate has been stable long enough
  assign accept   = (sync2_q == cand_q) && (cnt_q == HALL_CNT_W'(HALL_STABLE - 1));
  assign bad_code = (cand_q == 3'd0) || (cand_q == 3'd7);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      sync1_q    <= 3'd0;
      sync2_q    <= 3'd0;
      cand_q     <= 3'd0;
      cnt_q      <= '0;
      position_o <= 3'd1;
      fault_o    <= 1'b0;
    end
    else
    begin
      // Synchronizer
      sync1_q <= hall_i;
      sync2_q <= sync1_q;

      // The load cycle counts as the first stable one
      if (sync2_q != cand_q)
      begin
        cand_q <= sync2_q;
        cnt_q  <= HALL_CNT_W'(1);
      end
      else if (!accept)
      begin
        cnt_q <= cnt_q + HALL_CNT_W'(1);
      end

      if (accept && bad_code)
        fault_o <= 1'b1;
      else if (fault_clr_i)
        fault_o <= 1'b0;

      if (accept && !bad_code)
        position_o <= cand_q;
    end
  end

endmodule

/* bldc_regs.sv */
/*
 Wishbone classic slave with CTRL, DUTY and STATUS registers.
 Ack comes one cycle after cyc and stb and lasts one cycle.
 The master must drop stb after ack before the next access.
 fault_clr is write-one, a single-cycle pulse that reads back as 0.
*/
`timescale 1ns/100ps

module bldc_regs
  import bldc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  wb_req_t      wb_i,
  output wb_rsp_t      wb_o,
  input  motor_state_e state_i,
  input  logic         hall_fault_i,
  input  logic [2:0]   position_i,
  output motor_cfg_t   cfg_o
);

  // ------------------------------------------------
  // Handshake state
  // ------------------------------------------------
  logic             ack_q;
  logic             done_q;
  logic             access;
  logic [WB_DW-1:0] rdat_q;
  logic [WB_DW-1:0] rdat_mux;

  // Control register fields
  logic              run_q;
  logic              star_q;
  logic              dir_q;
  logic              clr_q;
  logic [DUTY_W-1:0] duty_q;

  // New access only when idle and the previous one has been released
  assign access = wb_i.cyc && wb_i.stb && !ack_q && !done_q;

  always_comb
  begin
    case (wb_i.adr)
      ADDR_CTRL:   rdat_mux = {12'd0, 1'b0, dir_q, star_q, run_q};
      ADDR_DUTY:   rdat_mux = {{(WB_DW - DUTY_W){1'b0}}, duty_q};
      ADDR_STATUS: rdat_mux = {10'd0, position_i, hall_fault_i, state_i};
      default:     rdat_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ack_q  <= 1'b0;
      done_q <= 1'b0;
      run_q  <= 1'b0;
      star_q <= 1'b0;
      dir_q  <= 1'b0;
      clr_q  <= 1'b0;
      duty_q <= '0;
    end
    else
    begin
      ack_q <= access;
      // Stays set until the master lets go of stb
      done_q <= wb_i.stb && (done_q || ack_q);
      // Pulse lasts one cycle
      clr_q <= 1'b0;
      if (access && wb_i.we)
      begin
        case (wb_i.adr)
          ADDR_CTRL:
          begin
            run_q  <= wb_i.dat[0];
            star_q <= wb_i.dat[1];
            dir_q  <= wb_i.dat[2];
            clr_q  <= wb_i.dat[3];
          end
          ADDR_DUTY:
          begin
            duty_q <= wb_i.dat[DUTY_W-1:0];
          end
          default:
          begin
            // STATUS is read-only
          end
        endcase
      end
    end
  end

  // Read data captured with the access, valid during ack
  always_ff @(posedge clk_i)
  begin
    if (access)
      rdat_q <= rdat_mux;
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdat_q;

  assign cfg_o.run       = run_q;
  assign cfg_o.star      = star_q;
  assign cfg_o.dir_cw    = dir_q;
  assign cfg_o.fault_clr = clr_q;
  assign cfg_o.duty      = duty_q;

  // Single-cycle ack even if the master is slow to drop stb
  a_ack_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.ack |=> !wb_o.ack);

endmodule

/* bldc_pkg.sv */
/*
 Shared constants and types of the BLDC gate driver.
 All timing is in clk_i cycles; one PWM period is 2**PWM_BITS cycles.
 Duty is one bit wider than the counter so full scale means 100 %.
 Wishbone bus is 16 bit data, 2 bit word address, no byte selects.
*/
package bldc_pkg;

  // ------------------------------------------------
  // Widths and timing
  // ------------------------------------------------
  localparam int PWM_BITS     = 8;
  localparam int DUTY_W       = PWM_BITS + 1;
  localparam int DEAD_CYCLES  = 4;
  localparam int ALIGN_CYCLES = 512;
  localparam int HALL_STABLE  = 3;

  // Counter widths derived from the constants above
  localparam int DEAD_W     = $clog2(DEAD_CYCLES + 1);
  localparam int ALIGN_W    = $clog2(ALIGN_CYCLES);
  localparam int HALL_CNT_W = $clog2(HALL_STABLE + 1);

  // Nine sixteenths of full scale
  localparam logic [DUTY_W-1:0] ALIGN_DUTY = DUTY_W'(9 * (2 ** PWM_BITS) / 16);

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  localparam int WB_AW = 2;
  localparam int WB_DW = 16;

  localparam logic [WB_AW-1:0] ADDR_CTRL   = 2'd0;
  localparam logic [WB_AW-1:0] ADDR_DUTY   = 2'd1;
  localparam logic [WB_AW-1:0] ADDR_STATUS = 2'd2;

  // ------------------------------------------------
  // Enums
  // ------------------------------------------------
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    ALIGN = 2'd1,
    RUN   = 2'd2
  } motor_state_e;

  // High leg is PWM modulated, low leg is held on
  typedef enum logic [1:0] {
    LEG_FLOAT = 2'd0,
    LEG_HIGH  = 2'd1,
    LEG_LOW   = 2'd2
  } leg_cmd_e;

  // Index 0 is phase A, 1 is B, 2 is C
  typedef leg_cmd_e [2:0] leg_set_t;

  // ------------------------------------------------
  // Structs
  // ------------------------------------------------
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic              run;
    logic              star;
    logic              dir_cw;
    logic              fault_clr;
    logic [DUTY_W-1:0] duty;
  } motor_cfg_t;

  typedef struct packed {
    logic hi;
    logic lo;
  } gate_pair_t;

endpackage
